// ==== cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath width and register file geometry.
`define CPU_DATA_W 32
`define CPU_REG_N 16
`define CPU_REG_AW 4

// Instruction word layout, bit positions inclusive.
`define CPU_OPC_HI 31
`define CPU_OPC_LO 28
`define CPU_IMMSEL_BIT 27
`define CPU_RD_HI 26
`define CPU_RD_LO 23
`define CPU_RS1_HI 22
`define CPU_RS1_LO 19
`define CPU_RS2_HI 18
`define CPU_RS2_LO 15
`define CPU_IMM_HI 14
`define CPU_IMM_LO 0

// Bit positions of the condition flags in the 32-bit flag word.
`define CPU_FLAG_Z 0
`define CPU_FLAG_N 1
`define CPU_FLAG_C 2
`define CPU_FLAG_V 3

`endif

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// Instruction opcodes. Codes 4'hA to 4'hF are undefined and act as a NOP.
	typedef enum logic [3:0] {
		OP_NOP = 4'h0,
		OP_ADD = 4'h1,
		OP_SUB = 4'h2,
		OP_MUL = 4'h3,
		OP_SHL = 4'h4,
		OP_SHR = 4'h5,
		OP_ROR = 4'h6,
		OP_MOVA = 4'h7,
		OP_MOVB = 4'h8,
		OP_ADDP = 4'h9
	} opcodeE;

	// ALU control bytes.
	// Bit 4 picks the arithmetic group, bit 5 the shift group, and
	// bits 2 and 1 the operation inside a group. With neither group bit
	// set, bit 7 and bit 2 choose between A, B and A plus B.
	typedef enum logic [7:0] {
		ALU_PASSA = 8'h00,
		ALU_ADD = 8'h10,
		ALU_SUB = 8'h12,
		ALU_MUL = 8'h14,
		ALU_SHL = 8'h20,
		ALU_SHR = 8'h22,
		ALU_ROR = 8'h24,
		ALU_PASSB = 8'h80,
		ALU_PASSAB = 8'h84
	} aluOpE;

endpackage

`default_nettype wire

// ==== cpu_alu.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cpu_params.svh"

module cpu_alu (
	input logic [`CPU_DATA_W-1:0] a,
	input logic [`CPU_DATA_W-1:0] b,
	input cpu_pkg::aluOpE op,
	output logic [`CPU_DATA_W-1:0] out,
	output logic [`CPU_DATA_W-1:0] flags
);

	import cpu_pkg::*;

	// One extra bit on add and subtract keeps the carry and the borrow.
	logic [`CPU_DATA_W:0] sum;
	logic [`CPU_DATA_W:0] diff;
	logic [`CPU_DATA_W-1:0] prod;
	logic [2*`CPU_DATA_W-1:0] rotWide;
	logic [`CPU_DATA_W-1:0] rotateOut;
	logic [`CPU_DATA_W-1:0] arithOut;
	logic [`CPU_DATA_W-1:0] shiftOut;
	logic [`CPU_DATA_W-1:0] upperOut;
	logic [`CPU_DATA_W-1:0] passOut;
	logic signA;
	logic signB;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};
	assign prod = a * b;

	// Rotate right by the low five bits of b using a doubled copy of a.
	assign rotWide = {a, a} >> b[4:0];
	assign rotateOut = rotWide[`CPU_DATA_W-1:0];

	// First mux level: multiply, subtract or add.
	assign arithOut = op[2] ? prod : op[1] ? diff[`CPU_DATA_W-1:0] : sum[`CPU_DATA_W-1:0];

	// Shifts use the full b, so any amount above 31 clears the result.
	assign shiftOut = op[2] ? rotateOut : op[1] ? (a >> b) : (a << b);

	assign upperOut = op[4] ? arithOut : shiftOut;
	assign passOut = op[7] ? (op[2] ? sum[`CPU_DATA_W-1:0] : b) : a;

	// Second mux level.
	assign out = (op[4] || op[5]) ? upperOut : passOut;

	assign signA = a[`CPU_DATA_W-1];
	assign signB = b[`CPU_DATA_W-1];

	always_comb begin
		flags = '0;
		flags[`CPU_FLAG_Z] = (out == '0);
		flags[`CPU_FLAG_N] = out[`CPU_DATA_W-1];
		if (op == ALU_ADD) begin
			flags[`CPU_FLAG_C] = sum[`CPU_DATA_W];
			flags[`CPU_FLAG_V] = (signA == signB) && (sum[`CPU_DATA_W-1] != signA);
		end else if (op == ALU_SUB) begin
			// Carry means no borrow, so it is set when a >= b unsigned.
			flags[`CPU_FLAG_C] = ~diff[`CPU_DATA_W];
			flags[`CPU_FLAG_V] = (signA != signB) && (diff[`CPU_DATA_W-1] != signA);
		end
	end

endmodule

`default_nettype wire

// ==== cpu_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cpu_params.svh"

module cpu_decoder (
	input logic [`CPU_DATA_W-1:0] instr,
	output cpu_pkg::aluOpE aluOp,
	output logic [`CPU_REG_AW-1:0] rd,
	output logic [`CPU_REG_AW-1:0] rs1,
	output logic [`CPU_REG_AW-1:0] rs2,
	output logic [`CPU_DATA_W-1:0] imm,
	output logic immSel,
	output logic writeEn
);

	import cpu_pkg::*;

	localparam int immW = `CPU_IMM_HI - `CPU_IMM_LO + 1;

	opcodeE opcode;
	logic [immW-1:0] immField;

	assign opcode = opcodeE'(instr[`CPU_OPC_HI:`CPU_OPC_LO]);

	assign rd = instr[`CPU_RD_HI:`CPU_RD_LO];
	assign rs1 = instr[`CPU_RS1_HI:`CPU_RS1_LO];
	assign rs2 = instr[`CPU_RS2_HI:`CPU_RS2_LO];
	assign immSel = instr[`CPU_IMMSEL_BIT];

	assign immField = instr[`CPU_IMM_HI:`CPU_IMM_LO];
	assign imm = {{(`CPU_DATA_W-immW){immField[immW-1]}}, immField};

	always_comb begin
		aluOp = ALU_PASSA;
		writeEn = 1'b1;
		case (opcode)
			OP_ADD: begin
				aluOp = ALU_ADD;
			end
			OP_SUB: begin
				aluOp = ALU_SUB;
			end
			OP_MUL: begin
				aluOp = ALU_MUL;
			end
			OP_SHL: begin
				aluOp = ALU_SHL;
			end
			OP_SHR: begin
				aluOp = ALU_SHR;
			end
			OP_ROR: begin
				aluOp = ALU_ROR;
			end
			OP_MOVA: begin
				aluOp = ALU_PASSA;
			end
			OP_MOVB: begin
				aluOp = ALU_PASSB;
			end
			OP_ADDP: begin
				aluOp = ALU_PASSAB;
			end
			default: begin
				// NOP and the undefined codes never reach write-back.
				writeEn = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== cpu_regfile.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cpu_params.svh"

module cpu_regfile (
	input logic clk,
	input logic rstN,
	input logic [`CPU_REG_AW-1:0] readAddrA,
	input logic [`CPU_REG_AW-1:0] readAddrB,
	output logic [`CPU_DATA_W-1:0] readDataA,
	output logic [`CPU_DATA_W-1:0] readDataB,
	input logic [`CPU_REG_AW-1:0] dbgAddr,
	output logic [`CPU_DATA_W-1:0] dbgData,
	input logic writeEn,
	input logic [`CPU_REG_AW-1:0] writeAddr,
	input logic [`CPU_DATA_W-1:0] writeData
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_REG_N];
	logic hitA;
	logic hitB;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU_REG_N; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// A write in flight this cycle is returned straight to the readers.
	assign hitA = writeEn && (writeAddr == readAddrA);
	assign hitB = writeEn && (writeAddr == readAddrB);

	assign readDataA = (readAddrA == '0) ? '0 : hitA ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : hitB ? writeData : regs[readAddrB];

	// The debug port sees only what is already stored.
	assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cpu_params.svh"

module cpu_core (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic [`CPU_DATA_W-1:0] instr,
	output logic resultValid,
	output logic [`CPU_REG_AW-1:0] resultReg,
	output logic [`CPU_DATA_W-1:0] result,
	output logic [`CPU_DATA_W-1:0] flags,
	input logic [`CPU_REG_AW-1:0] dbgAddr,
	output logic [`CPU_DATA_W-1:0] dbgData
);

	import cpu_pkg::*;

	// Decoder outputs for the incoming word.
	aluOpE decAluOp;
	logic [`CPU_REG_AW-1:0] decRd;
	logic [`CPU_REG_AW-1:0] decRs1;
	logic [`CPU_REG_AW-1:0] decRs2;
	logic [`CPU_DATA_W-1:0] decImm;
	logic decImmSel;
	logic decWriteEn;

	logic [`CPU_DATA_W-1:0] readDataA;
	logic [`CPU_DATA_W-1:0] readDataB;
	logic [`CPU_DATA_W-1:0] operandBNext;

	// Stage 1 registers.
	logic s1Valid;
	logic [`CPU_DATA_W-1:0] operandA;
	logic [`CPU_DATA_W-1:0] operandB;
	aluOpE s1AluOp;
	logic [`CPU_REG_AW-1:0] s1Rd;

	logic [`CPU_DATA_W-1:0] aluOut;
	logic [`CPU_DATA_W-1:0] aluFlags;

	cpu_decoder decoder (
		.instr(instr),
		.aluOp(decAluOp),
		.rd(decRd),
		.rs1(decRs1),
		.rs2(decRs2),
		.imm(decImm),
		.immSel(decImmSel),
		.writeEn(decWriteEn)
	);

	// The write port carries the stage 2 result, so a dependent
	// instruction issued right behind it reads the new value.
	cpu_regfile regfile (
		.clk(clk),
		.rstN(rstN),
		.readAddrA(decRs1),
		.readAddrB(decRs2),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.dbgAddr(dbgAddr),
		.dbgData(dbgData),
		.writeEn(s1Valid),
		.writeAddr(s1Rd),
		.writeData(aluOut)
	);

	cpu_alu alu (
		.a(operandA),
		.b(operandB),
		.op(s1AluOp),
		.out(aluOut),
		.flags(aluFlags)
	);

	assign operandBNext = decImmSel ? decImm : readDataB;

	// Stage 1 holds the operands and control for one instruction.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
		end else begin
			s1Valid <= instrValid && decWriteEn;
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin
			operandA <= readDataA;
			operandB <= operandBNext;
			s1AluOp <= decAluOp;
			s1Rd <= decRd;
		end
	end

	// Stage 2 latches the ALU result and flags and pulses resultValid.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			resultValid <= 1'b0;
			resultReg <= '0;
			result <= '0;
			flags <= '0;
		end else begin
			resultValid <= s1Valid;
			if (s1Valid) begin
				resultReg <= s1Rd;
				result <= aluOut;
				flags <= aluFlags;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_cpu_core.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cpu_params.svh"

module tb_cpu_core;

	import cpu_pkg::*;

	localparam int directedCount = 10 * 19;
	localparam int shiftIters = 40;
	localparam int chainCount = 40;
	localparam int chainLen = 8;
	localparam int streamCount = 1200;
	localparam int totalInstr = directedCount + shiftIters * 16 +
		chainCount * chainLen + streamCount;
	// Two clock periods per instruction, plus room for reset, gaps and drains.
	localparam int watchdogNs = totalInstr * 4 * 2 + 5000;

	logic clk;
	logic rstN;
	logic instrValid;
	logic [`CPU_DATA_W-1:0] instr;
	logic resultValid;
	logic [`CPU_REG_AW-1:0] resultReg;
	logic [`CPU_DATA_W-1:0] result;
	logic [`CPU_DATA_W-1:0] flags;
	logic [`CPU_REG_AW-1:0] dbgAddr;
	logic [`CPU_DATA_W-1:0] dbgData;

	integer seed = 33641;
	int cycle = 0;
	int dueCycle;
	string testName = "reset";
	int errorCount = 0;
	int checkCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int testStartErrors = 0;
	int pulseCount = 0;
	int resultsIssued = 0;

	// Reference model state and the results still expected from the DUT.
	logic [`CPU_DATA_W-1:0] regModel [`CPU_REG_N];
	logic [`CPU_DATA_W-1:0] expResult [$];
	logic [`CPU_REG_AW-1:0] expReg [$];
	logic [`CPU_DATA_W-1:0] expFlags [$];
	int expDue [$];

	cpu_core uut (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.resultValid(resultValid),
		.resultReg(resultReg),
		.result(result),
		.flags(flags),
		.dbgAddr(dbgAddr),
		.dbgData(dbgData)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] randWord();
		return $random(seed);
	endfunction

	// Expected result and flags, following the instruction set rules.
	task automatic aluRef(input opcodeE op, input logic [31:0] a, input logic [31:0] b,
			output logic [31:0] res, output logic [31:0] fl);
		int amt;
		fl = '0;
		amt = int'(b[4:0]);
		case (op)
			OP_ADD: begin
				res = a + b;
				fl[`CPU_FLAG_C] = (res < a);
				fl[`CPU_FLAG_V] = (a[31] == b[31]) && (res[31] != a[31]);
			end
			OP_SUB: begin
				res = a - b;
				fl[`CPU_FLAG_C] = (a >= b);
				fl[`CPU_FLAG_V] = (a[31] != b[31]) && (res[31] != a[31]);
			end
			OP_MUL: res = a * b;
			OP_SHL: res = (b > 32'd31) ? '0 : (a << b[4:0]);
			OP_SHR: res = (b > 32'd31) ? '0 : (a >> b[4:0]);
			OP_ROR: res = (amt == 0) ? a : ((a >> amt) | (a << (32 - amt)));
			OP_MOVA: res = a;
			OP_MOVB: res = b;
			OP_ADDP: res = a + b;
			default: res = '0;
		endcase
		fl[`CPU_FLAG_Z] = (res == '0);
		fl[`CPU_FLAG_N] = res[31];
	endtask

	task automatic checkResult(input string what, input logic [`CPU_DATA_W-1:0] exp,
			input logic [`CPU_DATA_W-1:0] act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("FAILED %s %s: expected %h, actual %h", testName, what, exp, act);
		end
	endtask

	task automatic checkFlags(input string what, input logic [`CPU_DATA_W-1:0] exp,
			input logic [`CPU_DATA_W-1:0] act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("FAILED %s %s: expected %b, actual %b", testName, what, exp[3:0], act[3:0]);
		end
	endtask

	task automatic checkReg(input string what, input logic [`CPU_REG_AW-1:0] exp,
			input logic [`CPU_REG_AW-1:0] act);
		checkCount++;
		if (act !== exp) begin
			errorCount++;
			$display("FAILED %s %s: expected r%0d, actual r%0d", testName, what, exp, act);
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testStartErrors = errorCount;
	endtask

	task automatic finishTest();
		testsRun++;
		if (errorCount == testStartErrors) begin
			$display("%s: ok", testName);
		end else begin
			testsFailed++;
			$display("%s: %0d errors", testName, errorCount - testStartErrors);
		end
	endtask

	task automatic issue(input logic [3:0] opc, input logic useImm, input logic [3:0] rd,
			input logic [3:0] rs1, input logic [3:0] rs2, input logic [14:0] imm);
		logic [31:0] word;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] fl;
		word = '0;
		word[`CPU_OPC_HI:`CPU_OPC_LO] = opc;
		word[`CPU_IMMSEL_BIT] = useImm;
		word[`CPU_RD_HI:`CPU_RD_LO] = rd;
		word[`CPU_RS1_HI:`CPU_RS1_LO] = rs1;
		word[`CPU_RS2_HI:`CPU_RS2_LO] = rs2;
		word[`CPU_IMM_HI:`CPU_IMM_LO] = imm;
		@(posedge clk);
		instrValid <= 1'b1;
		instr <= word;
		if (opc >= 4'd1 && opc <= 4'd9) begin
			a = regModel[rs1];
			b = useImm ? {{17{imm[14]}}, imm} : regModel[rs2];
			aluRef(opcodeE'(opc), a, b, res, fl);
			expResult.push_back(res);
			expFlags.push_back(fl);
			expReg.push_back(rd);
			// Sampled at the next edge, result visible after the one after.
			expDue.push_back(cycle + 3);
			resultsIssued++;
			if (rd != 4'd0) regModel[rd] = res;
		end
	endtask

	task automatic idle();
		@(posedge clk);
		instrValid <= 1'b0;
		instr <= randWord();
	endtask

	task automatic drain();
		int waited;
		idle();
		waited = 0;
		while (expResult.size() != 0 && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		if (expResult.size() != 0) begin
			errorCount++;
			$display("%s: %0d results never arrived", testName, expResult.size());
			expResult.delete();
			expFlags.delete();
			expReg.delete();
			expDue.delete();
		end
		repeat (3) @(negedge clk);
	endtask

	// Five instructions build any 32-bit value out of 15-bit immediates.
	task automatic loadReg(input logic [3:0] rd, input logic [31:0] v);
		issue(OP_ADD, 1'b1, rd, 4'd0, 4'd0, {5'd0, v[31:22]});
		issue(OP_SHL, 1'b1, rd, rd, 4'd0, 15'd11);
		issue(OP_ADD, 1'b1, rd, rd, 4'd0, {4'd0, v[21:11]});
		issue(OP_SHL, 1'b1, rd, rd, 4'd0, 15'd11);
		issue(OP_ADD, 1'b1, rd, rd, 4'd0, {4'd0, v[10:0]});
	endtask

	task automatic readDebug(input logic [3:0] addr, output logic [31:0] data);
		@(posedge clk);
		dbgAddr <= addr;
		@(negedge clk);
		data = dbgData;
	endtask

	task automatic resetTest();
		logic [31:0] data;
		startTest("reset");
		repeat (4) begin
			@(negedge clk);
			if (resultValid !== 1'b0) begin
				errorCount++;
				$display("reset: resultValid is high with no instruction issued");
			end
		end
		checkResult("result", '0, result);
		checkFlags("flags", '0, flags);
		for (int i = 0; i < `CPU_REG_N; i++) begin
			readDebug(4'(i), data);
			checkResult($sformatf("debug r%0d", i), '0, data);
		end
		finishTest();
	endtask

	task automatic directedPair(input logic [31:0] a, input logic [31:0] b);
		loadReg(4'd1, a);
		loadReg(4'd2, b);
		issue(OP_ADD, 1'b0, 4'd3, 4'd1, 4'd2, 15'd0);
		issue(OP_SUB, 1'b0, 4'd4, 4'd1, 4'd2, 15'd0);
		issue(OP_MUL, 1'b0, 4'd5, 4'd1, 4'd2, 15'd0);
		issue(OP_MOVA, 1'b0, 4'd6, 4'd1, 4'd2, 15'd0);
		issue(OP_MOVB, 1'b0, 4'd7, 4'd1, 4'd2, 15'd0);
		issue(OP_ADDP, 1'b0, 4'd8, 4'd1, 4'd2, 15'd0);
		issue(OP_ADD, 1'b1, 4'd9, 4'd1, 4'd0, b[14:0]);
		issue(OP_SUB, 1'b1, 4'd10, 4'd1, 4'd0, b[14:0]);
		issue(OP_MOVB, 1'b1, 4'd11, 4'd1, 4'd0, b[14:0]);
	endtask

	task automatic directedTest();
		startTest("directed arithmetic");
		directedPair(32'hFFFF_FFFF, 32'h0000_0001);
		directedPair(32'h7FFF_FFFF, 32'h0000_0001);
		directedPair(32'h8000_0000, 32'h8000_0000);
		directedPair(32'h0000_0005, 32'h0000_0007);
		directedPair(32'h0000_0007, 32'h0000_0007);
		directedPair(32'h8000_0000, 32'h0000_0001);
		directedPair(32'h7FFF_FFFF, 32'hFFFF_FFFF);
		directedPair(32'h0001_0000, 32'h0001_0000);
		directedPair(32'hFFFF_FFFF, 32'h0000_0003);
		directedPair(32'h0000_0000, 32'h0000_0000);
		drain();
		finishTest();
	endtask

	task automatic shiftTest();
		logic [31:0] amt;
		logic [14:0] imm;
		startTest("shift and rotate");
		for (int i = 0; i < shiftIters; i++) begin
			case (randWord() % 32'd3)
				0: amt = randWord() & 32'h1F;
				1: amt = 32'h20 | (randWord() & 32'h1F);
				default: amt = randWord();
			endcase
			imm = 15'(randWord());
			loadReg(4'd1, randWord());
			loadReg(4'd2, amt);
			issue(OP_SHL, 1'b0, 4'd3, 4'd1, 4'd2, 15'd0);
			issue(OP_SHR, 1'b0, 4'd4, 4'd1, 4'd2, 15'd0);
			issue(OP_ROR, 1'b0, 4'd5, 4'd1, 4'd2, 15'd0);
			issue(OP_SHL, 1'b1, 4'd6, 4'd1, 4'd0, imm);
			issue(OP_SHR, 1'b1, 4'd7, 4'd1, 4'd0, imm);
			issue(OP_ROR, 1'b1, 4'd8, 4'd1, 4'd0, imm);
		end
		drain();
		finishTest();
	endtask

	// Each instruction reads the register that the one before it writes.
	task automatic chainTest();
		logic [3:0] cur;
		logic [3:0] next;
		logic [3:0] src2;
		startTest("forwarding chain");
		for (int i = 0; i < chainCount; i++) begin
			cur = 4'(randWord());
			for (int j = 0; j < chainLen; j++) begin
				next = 4'(randWord());
				src2 = randWord() % 32'd2 == 0 ? cur : 4'(randWord());
				issue(4'd1 + 4'(randWord() % 32'd9), randWord() % 32'd4 == 0, next, cur,
					src2, 15'(randWord()));
				cur = next;
			end
		end
		drain();
		finishTest();
	endtask

	task automatic streamTest();
		logic [31:0] w;
		logic [31:0] data;
		int startPulses;
		int startIssued;
		startTest("random stream");
		startPulses = pulseCount;
		startIssued = resultsIssued;
		for (int i = 0; i < streamCount; i++) begin
			if (randWord() % 32'd8 == 0) begin
				repeat (1 + randWord() % 32'd3) idle();
			end
			w = randWord();
			issue(w[`CPU_OPC_HI:`CPU_OPC_LO], w[`CPU_IMMSEL_BIT], w[`CPU_RD_HI:`CPU_RD_LO],
				w[`CPU_RS1_HI:`CPU_RS1_LO], w[`CPU_RS2_HI:`CPU_RS2_LO],
				w[`CPU_IMM_HI:`CPU_IMM_LO]);
		end
		drain();
		checkCount++;
		if (pulseCount - startPulses != resultsIssued - startIssued) begin
			errorCount++;
			$display("FAILED %s pulse count: expected %0d, actual %0d", testName,
				resultsIssued - startIssued, pulseCount - startPulses);
		end
		readDebug(4'd0, data);
		checkResult("debug r0", '0, data);
		finishTest();
	endtask

	task automatic registerTest();
		logic [31:0] data;
		startTest("register file");
		for (int i = 0; i < `CPU_REG_N; i++) begin
			readDebug(4'(i), data);
			checkResult($sformatf("debug r%0d", i), regModel[i], data);
		end
		finishTest();
	endtask

	// Every result pulse is matched against the oldest outstanding instruction.
	always @(negedge clk) begin
		if (rstN && resultValid === 1'b1) begin
			pulseCount++;
			if (expResult.size() == 0) begin
				errorCount++;
				$display("%s: resultValid pulsed with no instruction outstanding", testName);
			end else begin
				checkResult("result", expResult.pop_front(), result);
				checkFlags("flags", expFlags.pop_front(), flags);
				checkReg("resultReg", expReg.pop_front(), resultReg);
				dueCycle = expDue.pop_front();
				checkCount++;
				if (cycle != dueCycle) begin
					errorCount++;
					$display("FAILED %s latency: expected cycle %0d, actual cycle %0d",
						testName, dueCycle, cycle);
				end
			end
		end
	end

	initial begin
		#(watchdogNs);
		$display("Timeout: the run did not finish within %0d ns", watchdogNs);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		dbgAddr = '0;
		for (int i = 0; i < `CPU_REG_N; i++) regModel[i] = '0;
		repeat (16) @(posedge clk);
		rstN <= 1'b1;
		resetTest();
		directedTest();
		shiftTest();
		chainTest();
		streamTest();
		registerTest();
		$display("Tests run %0d, failed %0d, checks %0d, errors %0d", testsRun, testsFailed,
			checkCount, errorCount);
		if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
cpu_pkg.sv
cpu_alu.sv
cpu_decoder.sv
cpu_regfile.sv
cpu_core.sv
tb_cpu_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = tb_cpu_core
FILELIST = verilog.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
